// ==== hw/jtagSettings.svh ====
// JTAG debug port settings
`ifndef JTAG_SETTINGS_SVH
`define JTAG_SETTINGS_SVH

// Register widths
`define IR_WIDTH 4
`define DR_WIDTH 32

// Instruction codes with bypass for any other value
`define IR_BYPASS 4'b1111
`define IR_STATUS 4'b0010
`define IR_JDCR 4'b0100
`define IR_DBDR 4'b1000

// Loaded into the IR shift stage in Capture-IR
`define IR_CAPTURE 4'b0001

// Pin synchronizer depth
`define SYNC_STAGES 2

`endif

// ==== hw/jtagPkg.sv ====
// JTAG debug port types
`default_nettype none

`include "jtagSettings.svh"

package jtagPkg;

  typedef logic [`IR_WIDTH-1:0] irCode_t;
  typedef logic [`DR_WIDTH-1:0] dataWord_t;

  // Sixteen TAP controller states
  typedef enum logic [3:0] {
    stTestLogicReset, stRunTestIdle,
    stSelectDrScan, stCaptureDr, stShiftDr, stExit1Dr, stPauseDr, stExit2Dr, stUpdateDr,
    stSelectIrScan, stCaptureIr, stShiftIr, stExit1Ir, stPauseIr, stExit2Ir, stUpdateIr
  } tapState_e;

  // Decoded TAP strobes with the shift flags and TLR as levels
  typedef struct packed {
    logic testLogicReset;
    logic captureIr;
    logic shiftIr;
    logic updateIr;
    logic captureDr;
    logic shiftDr;
    logic updateDr;
  } tapCtrl_t;

  // Synchronized pins and TCK edge strobes
  typedef struct packed {
    logic tckRise;
    logic tckFall;
    logic tms;
    logic tdi;
    logic trstN;
  } tckEvent_t;

  // One-hot data register select
  typedef struct packed {
    logic bypass;
    logic status;
    logic jdcr;
    logic dbdr;
  } drSelect_t;

  // Debug control register layout with bit 0 at the bottom
  typedef struct packed {
    logic       reserved;
    logic       dbgWaitEn;
    logic       freezeTimers;
    logic       uncondEvent;
    logic [1:0] resetCode;
    logic       stopReq;
  } jdcr_t;

  typedef struct packed {
    logic stopReq;
    logic uncondEvent;
    logic freezeTimers;
    logic dbgWaitEn;
  } debugCtrl_t;

  typedef struct packed {
    logic core;
    logic chip;
    logic system;
  } resetReq_t;

endpackage

`default_nettype wire

// ==== hw/tckSampler.sv ====
// JTAG pin synchronizer
`timescale 1ns/10ps
`default_nettype none

`include "jtagSettings.svh"

module tckSampler
  import jtagPkg::*;
(
  input  wire       CB,
  input  wire       rstN_i,
  input  wire       tck_i,
  input  wire       tms_i,
  input  wire       tdi_i,
  input  wire       trstN_i,
  output tckEvent_t tckEvent_o
);

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trstN;
  } pinSample_t;

  // TCK low, TMS and TDI pulled up, TRST inactive
  localparam pinSample_t pinIdle = 4'b0111;

  pinSample_t                    pinIn;
  pinSample_t                    pinSync;
  pinSample_t [`SYNC_STAGES-1:0] syncQ;
  logic                          tckPrevQ;

  assign pinIn = {tck_i, tms_i, tdi_i, trstN_i};

  // ******************************
  // Synchronizer chain and TCK edge flop
  always_ff @(posedge CB)
  begin
    if (!rstN_i)
    begin
      syncQ    <= {`SYNC_STAGES{pinIdle}};
      tckPrevQ <= 1'b0;
    end
    else
    begin
      syncQ    <= {syncQ[`SYNC_STAGES-2:0], pinIn};
      tckPrevQ <= pinSync.tck;
    end
  end

  assign pinSync = syncQ[`SYNC_STAGES-1];

  assign tckEvent_o = '{
    tckRise: pinSync.tck & ~tckPrevQ,
    tckFall: ~pinSync.tck & tckPrevQ,
    tms:     pinSync.tms,
    tdi:     pinSync.tdi,
    trstN:   pinSync.trstN
  };

endmodule

`default_nettype wire

// ==== hw/tapController.sv ====
// TAP controller state machine
`timescale 1ns/10ps
`default_nettype none

module tapController
  import jtagPkg::*;
(
  input  wire       CB,
  input  wire       rstN_i,
  input  wire       tckEvent_t tckEvent_i,
  output tapCtrl_t  tapCtrl_o
);

  tapState_e stateQ;
  tapState_e stateNext;
  logic      tms;
  // One CB cycle after each state move
  logic      stepQ;

  assign tms = tckEvent_i.tms;

  // ******************************
  // Standard TMS transition table
  always_comb
  begin
    case (stateQ)
      stTestLogicReset: stateNext = tms ? stTestLogicReset : stRunTestIdle;
      stRunTestIdle:    stateNext = tms ? stSelectDrScan : stRunTestIdle;
      stSelectDrScan:   stateNext = tms ? stSelectIrScan : stCaptureDr;
      stCaptureDr:      stateNext = tms ? stExit1Dr : stShiftDr;
      stShiftDr:        stateNext = tms ? stExit1Dr : stShiftDr;
      stExit1Dr:        stateNext = tms ? stUpdateDr : stPauseDr;
      stPauseDr:        stateNext = tms ? stExit2Dr : stPauseDr;
      stExit2Dr:        stateNext = tms ? stUpdateDr : stShiftDr;
      stUpdateDr:       stateNext = tms ? stSelectDrScan : stRunTestIdle;
      stSelectIrScan:   stateNext = tms ? stTestLogicReset : stCaptureIr;
      stCaptureIr:      stateNext = tms ? stExit1Ir : stShiftIr;
      stShiftIr:        stateNext = tms ? stExit1Ir : stShiftIr;
      stExit1Ir:        stateNext = tms ? stUpdateIr : stPauseIr;
      stPauseIr:        stateNext = tms ? stExit2Ir : stPauseIr;
      stExit2Ir:        stateNext = tms ? stUpdateIr : stShiftIr;
      stUpdateIr:       stateNext = tms ? stSelectDrScan : stRunTestIdle;
      default:          stateNext = stTestLogicReset;
    endcase
  end

  // TRST overrides any TCK activity
  always_ff @(posedge CB)
  begin
    if (!rstN_i || !tckEvent_i.trstN)
    begin
      stateQ <= stTestLogicReset;
      stepQ  <= 1'b0;
    end
    else
    begin
      if (tckEvent_i.tckRise)
      begin
        stateQ <= stateNext;
      end
      stepQ <= tckEvent_i.tckRise;
    end
  end

  // ******************************
  // Strobe decode
  // Capture fires on the rise that leaves Capture and update one cycle after entry
  assign tapCtrl_o = '{
    testLogicReset: stateQ == stTestLogicReset,
    captureIr:      tckEvent_i.tckRise && stateQ == stCaptureIr,
    shiftIr:        stateQ == stShiftIr,
    updateIr:       stepQ && stateQ == stUpdateIr,
    captureDr:      tckEvent_i.tckRise && stateQ == stCaptureDr,
    shiftDr:        stateQ == stShiftDr,
    updateDr:       stepQ && stateQ == stUpdateDr
  };

  stateKnown: assert property (@(posedge CB) disable iff (!rstN_i) !$isunknown(stateQ));

endmodule

`default_nettype wire

// ==== hw/instructionRegister.sv ====
// JTAG instruction register
`timescale 1ns/10ps
`default_nettype none

`include "jtagSettings.svh"

module instructionRegister
  import jtagPkg::*;
(
  input  wire       CB,
  input  wire       rstN_i,
  input  wire       tckEvent_t tckEvent_i,
  input  wire       tapCtrl_t tapCtrl_i,
  output drSelect_t drSel_o,
  output logic      irTdo_o
);

  irCode_t irShiftQ;
  irCode_t irUpdateQ;

  // Shift stage with the LSB out first
  always_ff @(posedge CB)
  begin
    if (!rstN_i)
    begin
      irShiftQ <= `IR_CAPTURE;
    end
    else if (tapCtrl_i.captureIr)
    begin
      irShiftQ <= `IR_CAPTURE;
    end
    else if (tckEvent_i.tckRise && tapCtrl_i.shiftIr)
    begin
      irShiftQ <= {tckEvent_i.tdi, irShiftQ[`IR_WIDTH-1:1]};
    end
  end

  // Update stage falls back to BYPASS in TLR
  always_ff @(posedge CB)
  begin
    if (!rstN_i || tapCtrl_i.testLogicReset)
    begin
      irUpdateQ <= `IR_BYPASS;
    end
    else if (tapCtrl_i.updateIr)
    begin
      irUpdateQ <= irShiftQ;
    end
  end

  // ******************************
  // Data register select
  always_comb
  begin
    drSel_o = '0;
    case (irUpdateQ)
      `IR_STATUS: drSel_o.status = 1'b1;
      `IR_JDCR:   drSel_o.jdcr   = 1'b1;
      `IR_DBDR:   drSel_o.dbdr   = 1'b1;
      default:    drSel_o.bypass = 1'b1;
    endcase
  end

  assign irTdo_o = irShiftQ[0];

  drSelOneHot: assert property (@(posedge CB) disable iff (!rstN_i) $onehot(drSel_o));

endmodule

`default_nettype wire

// ==== hw/scanDataPath.sv ====
// Bypass bit, shared data shift register and TDO
`timescale 1ns/10ps
`default_nettype none

`include "jtagSettings.svh"

module scanDataPath
  import jtagPkg::*;
(
  input  wire        CB,
  input  wire        rstN_i,
  input  wire        tckEvent_t tckEvent_i,
  input  wire        tapCtrl_t tapCtrl_i,
  input  wire        drSelect_t drSel_i,
  input  wire        irTdo_i,
  input  wire        dataWord_t coreStatus_i,
  input  wire        jdcr_t jdcrRead_i,
  input  wire        dataWord_t dbdrRead_i,
  output dataWord_t  shiftWord_o,
  output logic       tdo_o,
  output logic       tdoEnable_o
);

  logic      bypassQ;
  dataWord_t shiftQ;
  dataWord_t captureWord;
  logic      drTdo;
  logic      shiftStep;

  assign shiftStep = tckEvent_i.tckRise & tapCtrl_i.shiftDr;

  // Capture source with zero for bypass
  always_comb
  begin
    captureWord = '0;
    if (drSel_i.status)
    begin
      captureWord = coreStatus_i;
    end
    else if (drSel_i.jdcr)
    begin
      captureWord = {{(`DR_WIDTH - $bits(jdcr_t)){1'b0}}, jdcrRead_i};
    end
    else if (drSel_i.dbdr)
    begin
      captureWord = dbdrRead_i;
    end
  end

  // ******************************
  // Bypass bit and shift register
  always_ff @(posedge CB)
  begin
    if (!rstN_i)
    begin
      bypassQ <= 1'b0;
      shiftQ  <= '0;
    end
    else if (tapCtrl_i.captureDr)
    begin
      bypassQ <= 1'b0;
      shiftQ  <= captureWord;
    end
    else if (shiftStep && drSel_i.bypass)
    begin
      bypassQ <= tckEvent_i.tdi;
    end
    else if (shiftStep)
    begin
      // TDI enters at the MSB
      shiftQ <= {tckEvent_i.tdi, shiftQ[`DR_WIDTH-1:1]};
    end
  end

  assign drTdo = drSel_i.bypass ? bypassQ : shiftQ[0];

  // ******************************
  // TDO changes on the falling TCK edge only
  always_ff @(posedge CB)
  begin
    if (!rstN_i || tapCtrl_i.testLogicReset)
    begin
      tdo_o       <= 1'b0;
      tdoEnable_o <= 1'b0;
    end
    else if (tckEvent_i.tckFall)
    begin
      tdoEnable_o <= tapCtrl_i.shiftIr | tapCtrl_i.shiftDr;
      if (tapCtrl_i.shiftIr)
      begin
        tdo_o <= irTdo_i;
      end
      else
      begin
        tdo_o <= tapCtrl_i.shiftDr & drTdo;
      end
    end
  end

  assign shiftWord_o = shiftQ;

endmodule

`default_nettype wire

// ==== hw/debugControlReg.sv ====
// Debug control and data buffer registers
`timescale 1ns/10ps
`default_nettype none

module debugControlReg
  import jtagPkg::*;
(
  input  wire        CB,
  input  wire        rstN_i,
  input  wire        tapCtrl_t tapCtrl_i,
  input  wire        drSelect_t drSel_i,
  input  wire        dataWord_t shiftWord_i,
  input  wire        dataWord_t dbdrIn_i,
  output jdcr_t      jdcrRead_o,
  output dataWord_t  dbdrRead_o,
  output debugCtrl_t debugCtrl_o,
  output resetReq_t  resetReq_o,
  output dataWord_t  dbdr_o,
  output logic       dbdrPulse_o
);

  jdcr_t     jdcrQ;
  jdcr_t     jdcrNext;
  dataWord_t dbdrQ;
  dataWord_t dbdrInQ;
  logic      pulseQ;
  logic      jdcrWrite;
  logic      dbdrWrite;

  assign jdcrWrite = tapCtrl_i.updateDr & drSel_i.jdcr;
  assign dbdrWrite = tapCtrl_i.updateDr & drSel_i.dbdr;

  // Low bits of the scanned word with the reserved bit forced to zero
  always_comb
  begin
    jdcrNext          = jdcr_t'(shiftWord_i[$bits(jdcr_t)-1:0]);
    jdcrNext.reserved = 1'b0;
  end

  // ******************************
  // JDCR cleared in TLR
  always_ff @(posedge CB)
  begin
    if (!rstN_i || tapCtrl_i.testLogicReset)
    begin
      jdcrQ <= '0;
    end
    else if (jdcrWrite)
    begin
      jdcrQ <= jdcrNext;
    end
  end

  // DBDR survives TLR; core word sampled every cycle
  always_ff @(posedge CB)
  begin
    if (!rstN_i)
    begin
      dbdrQ   <= '0;
      dbdrInQ <= '0;
      pulseQ  <= 1'b0;
    end
    else
    begin
      if (dbdrWrite)
      begin
        dbdrQ <= shiftWord_i;
      end
      dbdrInQ <= dbdrIn_i;
      pulseQ  <= dbdrWrite;
    end
  end

  // ******************************
  // Core side outputs
  assign debugCtrl_o = '{
    stopReq:      jdcrQ.stopReq,
    uncondEvent:  jdcrQ.uncondEvent,
    freezeTimers: jdcrQ.freezeTimers,
    dbgWaitEn:    jdcrQ.dbgWaitEn
  };

  // 01 core, 10 chip, 11 system
  assign resetReq_o = '{
    core:   jdcrQ.resetCode == 2'b01,
    chip:   jdcrQ.resetCode == 2'b10,
    system: jdcrQ.resetCode == 2'b11
  };

  assign jdcrRead_o  = jdcrQ;
  assign dbdrRead_o  = dbdrInQ;
  assign dbdr_o      = dbdrQ;
  assign dbdrPulse_o = pulseQ;

  resetReqExclusive: assert property (@(posedge CB) disable iff (!rstN_i)
    $onehot0(resetReq_o));

endmodule

`default_nettype wire

// ==== hw/jtagDebugTop.sv ====
// JTAG debug port top level
`timescale 1ns/10ps
`default_nettype none

module jtagDebugTop
  import jtagPkg::*;
(
  input  wire        CB,
  input  wire        rstN_i,
  input  wire        tck_i,
  input  wire        tms_i,
  input  wire        tdi_i,
  input  wire        trstN_i,
  input  wire        dataWord_t coreStatus_i,
  input  wire        dataWord_t dbdrIn_i,
  output logic       tdo_o,
  output logic       tdoEnable_o,
  output debugCtrl_t debugCtrl_o,
  output resetReq_t  resetReq_o,
  output dataWord_t  dbdr_o,
  output logic       dbdrPulse_o
);

  tckEvent_t tckEvent;
  tapCtrl_t  tapCtrl;
  drSelect_t drSel;
  logic      irTdo;
  dataWord_t shiftWord;
  jdcr_t     jdcrRead;
  dataWord_t dbdrRead;

  // ******************************
  // TAP front end
  tckSampler tckSampler_i (
    .CB         (CB),
    .rstN_i     (rstN_i),
    .tck_i      (tck_i),
    .tms_i      (tms_i),
    .tdi_i      (tdi_i),
    .trstN_i    (trstN_i),
    .tckEvent_o (tckEvent)
  );

  tapController tapController_i (
    .CB         (CB),
    .rstN_i     (rstN_i),
    .tckEvent_i (tckEvent),
    .tapCtrl_o  (tapCtrl)
  );

  instructionRegister instructionRegister_i (
    .CB         (CB),
    .rstN_i     (rstN_i),
    .tckEvent_i (tckEvent),
    .tapCtrl_i  (tapCtrl),
    .drSel_o    (drSel),
    .irTdo_o    (irTdo)
  );

  // ******************************
  // Data registers
  scanDataPath scanDataPath_i (
    .CB           (CB),
    .rstN_i       (rstN_i),
    .tckEvent_i   (tckEvent),
    .tapCtrl_i    (tapCtrl),
    .drSel_i      (drSel),
    .irTdo_i      (irTdo),
    .coreStatus_i (coreStatus_i),
    .jdcrRead_i   (jdcrRead),
    .dbdrRead_i   (dbdrRead),
    .shiftWord_o  (shiftWord),
    .tdo_o        (tdo_o),
    .tdoEnable_o  (tdoEnable_o)
  );

  debugControlReg debugControlReg_i (
    .CB          (CB),
    .rstN_i      (rstN_i),
    .tapCtrl_i   (tapCtrl),
    .drSel_i     (drSel),
    .shiftWord_i (shiftWord),
    .dbdrIn_i    (dbdrIn_i),
    .jdcrRead_o  (jdcrRead),
    .dbdrRead_o  (dbdrRead),
    .debugCtrl_o (debugCtrl_o),
    .resetReq_o  (resetReq_o),
    .dbdr_o      (dbdr_o),
    .dbdrPulse_o (dbdrPulse_o)
  );

endmodule

`default_nettype wire

// ==== tests/jtagDriver.svh ====
// JTAG pin driver tasks
`ifndef JTAG_DRIVER_SVH
`define JTAG_DRIVER_SVH

// CB cycles per TCK level
localparam int tckHold = 6;

// One TCK period entered and left on a falling CB edge
task automatic tckCycle(input logic tmsV, input logic tdiV, output logic tdoV,
                        output logic enV);
  tck_i = 1'b0;
  tms_i = tmsV;
  tdi_i = tdiV;
  repeat (tckHold) @(negedge CB);
  // TDO has settled since the falling TCK edge
  tdoV  = tdo_o;
  enV   = tdoEnable_o;
  tck_i = 1'b1;
  repeat (tckHold) @(negedge CB);
endtask

task automatic tmsStep(input logic tmsV);
  logic unusedTdo;
  logic unusedEn;
  tckCycle(tmsV, 1'b0, unusedTdo, unusedEn);
endtask

// Shift n bits LSB first with TMS high on the last one to reach Exit1
task automatic shiftBits(input int n, input logic [63:0] dIn, output logic [63:0] dOut,
                         output logic enAll);
  logic tdoV;
  logic enV;
  int   i;
  dOut  = '0;
  enAll = 1'b1;
  for (i = 0; i < n; i++)
  begin
    tckCycle(i == n - 1, dIn[i], tdoV, enV);
    dOut[i] = tdoV;
    enAll   = enAll & enV;
  end
endtask

// ******************************
// Full scans from Run-Test-Idle back to Run-Test-Idle
task automatic scanIr(input int n, input logic [63:0] dIn, output logic [63:0] dOut,
                      output logic enAll);
  tmsStep(1'b1);
  tmsStep(1'b1);
  tmsStep(1'b0);
  tmsStep(1'b0);
  shiftBits(n, dIn, dOut, enAll);
  tmsStep(1'b1);
  tmsStep(1'b0);
endtask

task automatic scanDr(input int n, input logic [63:0] dIn, output logic [63:0] dOut,
                      output logic enAll);
  tmsStep(1'b1);
  tmsStep(1'b0);
  tmsStep(1'b0);
  shiftBits(n, dIn, dOut, enAll);
  tmsStep(1'b1);
  tmsStep(1'b0);
endtask

// Five TMS-high cycles reach Test-Logic-Reset from anywhere
task automatic resetTap();
  repeat (5) tmsStep(1'b1);
  tmsStep(1'b0);
endtask

`endif

// ==== tests/tbJtagDebug.sv ====
// JTAG debug port testbench
`timescale 1ns/10ps
`default_nettype none

`include "jtagSettings.svh"

module tbJtagDebug
  import jtagPkg::*;
();

  logic       CB;
  logic       rstN_i;
  logic       tck_i;
  logic       tms_i;
  logic       tdi_i;
  logic       trstN_i;
  dataWord_t  coreStatus_i;
  dataWord_t  dbdrIn_i;
  logic       tdo_o;
  logic       tdoEnable_o;
  debugCtrl_t debugCtrl_o;
  resetReq_t  resetReq_o;
  dataWord_t  dbdr_o;
  logic       dbdrPulse_o;

  integer     seed;
  int         pulseCount;
  int         dbdrWrites;
  int         base;
  dataWord_t  word;
  logic [63:0] irOut;
  logic        irEn;
  // Model state
  logic [6:0] expJdcr;
  dataWord_t  expDbdr;
  irCode_t    expIr;

  `include "jtagDriver.svh"

  jtagDebugTop jtagDebugTop_i (
    .CB           (CB),
    .rstN_i       (rstN_i),
    .tck_i        (tck_i),
    .tms_i        (tms_i),
    .tdi_i        (tdi_i),
    .trstN_i      (trstN_i),
    .coreStatus_i (coreStatus_i),
    .dbdrIn_i     (dbdrIn_i),
    .tdo_o        (tdo_o),
    .tdoEnable_o  (tdoEnable_o),
    .debugCtrl_o  (debugCtrl_o),
    .resetReq_o   (resetReq_o),
    .dbdr_o       (dbdr_o),
    .dbdrPulse_o  (dbdrPulse_o)
  );

  always #50 CB = ~CB;

  // Count buffer write pulses as the core sees them
  always @(posedge CB)
  begin
    if (!rstN_i)
    begin
      pulseCount <= 0;
    end
    else if (dbdrPulse_o)
    begin
      pulseCount <= pulseCount + 1;
    end
  end

  // ******************************
  // Checking and model
  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic waitPulses(input int target);
    int waited;
    waited = 0;
    while (pulseCount < target && waited < 200)
    begin
      @(negedge CB);
      waited++;
    end
    if (pulseCount < target)
    begin
      $display("No dbdrPulse_o seen within 200 cycles of a DBDR write");
      $display("STATUS: FAIL");
      $fatal(1, "Pulse timeout");
    end
  endtask

  function automatic dataWord_t randomWord();
    return $random(seed);
  endfunction

  // Core-side outputs from the JDCR field layout
  task automatic checkJdcrOutputs();
    logic [3:0] ctrl;
    logic [2:0] rst;
    ctrl = {expJdcr[0], expJdcr[3], expJdcr[4], expJdcr[5]};
    rst  = {expJdcr[2:1] == 2'b01, expJdcr[2:1] == 2'b10, expJdcr[2:1] == 2'b11};
    checkValue("debugCtrl_o", 64'(debugCtrl_o), 64'(ctrl));
    checkValue("resetReq_o", 64'(resetReq_o), 64'(rst));
  endtask

  task automatic checkIdle();
    checkJdcrOutputs();
    checkValue("tdoEnable_o", 64'(tdoEnable_o), 64'd0);
    checkValue("dbdrPulse_o", 64'(dbdrPulse_o), 64'd0);
  endtask

  task automatic loadIr(input irCode_t code);
    logic [63:0] dOut;
    logic        enAll;
    scanIr(`IR_WIDTH, 64'(code), dOut, enAll);
    checkValue("tdoEnable_o in Shift-IR", 64'(enAll), 64'd1);
    checkValue("tdo_o IR capture", dOut, 64'(`IR_CAPTURE));
    expIr = code;
  endtask

  // One DR scan with the expected capture picked by the model instruction
  task automatic dataScan(input dataWord_t scanWord);
    logic [63:0] dOut;
    logic [63:0] expOut;
    logic        enAll;
    case (expIr)
      `IR_STATUS: expOut = 64'(coreStatus_i);
      `IR_JDCR:   expOut = 64'(expJdcr);
      `IR_DBDR:   expOut = 64'(dbdrIn_i);
      default:    expOut = 64'({scanWord[30:0], 1'b0});
    endcase
    scanDr(`DR_WIDTH, 64'(scanWord), dOut, enAll);
    checkValue("tdoEnable_o in Shift-DR", 64'(enAll), 64'd1);
    checkValue("tdo_o DR scan", dOut, expOut);
    if (expIr == `IR_JDCR)
    begin
      expJdcr = {1'b0, scanWord[5:0]};
    end
    else if (expIr == `IR_DBDR)
    begin
      expDbdr = scanWord;
      dbdrWrites++;
    end
  endtask

  // ******************************
  // Stimulus
  initial
  begin
    seed         = 32'hafb43733;
    CB           = 1'b0;
    rstN_i       = 1'b0;
    tck_i        = 1'b0;
    tms_i        = 1'b1;
    tdi_i        = 1'b0;
    trstN_i      = 1'b1;
    coreStatus_i = '0;
    dbdrIn_i     = '0;
    expJdcr      = '0;
    expDbdr      = '0;
    expIr        = `IR_BYPASS;
    dbdrWrites   = 0;
    repeat (16) @(negedge CB);
    rstN_i = 1'b1;
    repeat (4) @(negedge CB);

    // Reset state and bypass
    checkIdle();
    checkValue("dbdr_o", 64'(dbdr_o), 64'd0);
    tmsStep(1'b0);
    dataScan(randomWord());

    // IR capture pattern then the shifted bits
    word = randomWord();
    scanIr(8, 64'(word[7:0]), irOut, irEn);
    checkValue("tdoEnable_o in long IR scan", 64'(irEn), 64'd1);
    checkValue("tdo_o long IR scan", irOut, 64'({word[3:0], `IR_CAPTURE}));
    expIr = word[7:4];

    loadIr(`IR_STATUS);
    repeat (4)
    begin
      coreStatus_i = randomWord();
      dataScan(randomWord());
    end

    // JDCR write and a second scan that reads it back
    loadIr(`IR_JDCR);
    repeat (20)
    begin
      word = randomWord();
      dataScan(word);
      checkJdcrOutputs();
      dataScan(word);
      checkJdcrOutputs();
    end

    // DBDR writes with the core echoing the buffer back on dbdrIn_i
    loadIr(`IR_DBDR);
    dbdrIn_i = randomWord();
    repeat (8)
    begin
      base = pulseCount;
      dataScan(randomWord());
      waitPulses(base + 1);
      repeat (20) @(negedge CB);
      checkValue("dbdrPulse_o count", 64'(pulseCount), 64'(base + 1));
      checkValue("dbdr_o", 64'(dbdr_o), 64'(expDbdr));
      dbdrIn_i = expDbdr;
    end

    // TMS reset clears the JDCR and restores bypass
    loadIr(`IR_JDCR);
    dataScan(randomWord() | 32'h1);
    checkJdcrOutputs();
    resetTap();
    expJdcr = '0;
    expIr   = `IR_BYPASS;
    checkIdle();
    checkValue("dbdr_o after TLR", 64'(dbdr_o), 64'(expDbdr));
    dataScan(randomWord());

    // Same through the TRST pin
    loadIr(`IR_JDCR);
    dataScan(randomWord() | 32'h1);
    checkJdcrOutputs();
    trstN_i = 1'b0;
    repeat (8) @(negedge CB);
    trstN_i = 1'b1;
    repeat (8) @(negedge CB);
    tmsStep(1'b0);
    expJdcr = '0;
    expIr   = `IR_BYPASS;
    checkIdle();
    dataScan(randomWord());

    checkValue("total dbdrPulse_o count", 64'(pulseCount), 64'(dbdrWrites));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
+incdir+tests
hw/jtagPkg.sv
hw/tckSampler.sv
hw/tapController.sv
hw/instructionRegister.sv
hw/scanDataPath.sv
hw/debugControlReg.sv
hw/jtagDebugTop.sv
tests/tbJtagDebug.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbJtagDebug
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass or fail comes from the log, not the exit status
run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
